/* calc_pkg.sv */
// datapath sizes and types shared by the calculator blocks
package calc_pkg;

  // operand and register width
  localparam int DATA_W = 4;

  // number of registers in the register file
  localparam int NUM_REGS = 4;

  // register number width, enough for NUM_REGS entries
  localparam int ADDR_W = 2;

  // one register word
  // signed because rd_data, add, sub and slt all treat it
  // as two's complement
  typedef logic signed [DATA_W-1:0] data_t;

  // register number, used for both the read and the write side
  typedef logic [ADDR_W-1:0] reg_addr_t;

endpackage

/* alu_pkg.sv */
// ALU operation codes
package alu_pkg;

  // width of the control field
  localparam int OP_W = 3;

  // operation select, values follow the lab encoding
  //   bit 2 set means b is inverted (logic ops)
  //   or subtracted (arith ops)
  typedef enum logic [OP_W-1:0] {
    OP_AND  = 3'd0, // a & b
    OP_OR   = 3'd1, // a | b
    OP_ADD  = 3'd2, // a + b, wraps
    OP_ZERO = 3'd3, // constant 0
    OP_ANDN = 3'd4, // a & ~b
    OP_ORN  = 3'd5, // a | ~b
    OP_SUB  = 3'd6, // a - b, wraps
    OP_SLT  = 3'd7  // 1 if a < b as signed values
  } alu_op_t;

endpackage

/* calc_alu.sv */
`timescale 1ns/1ps

module calc_alu (
  input  calc_pkg::data_t  a,      // register operand
  input  calc_pkg::data_t  b,      // immediate operand
  input  alu_pkg::alu_op_t op,
  output calc_pkg::data_t  result
);

  // sign-extended width for the shared adder
  localparam int EXT_W = calc_pkg::DATA_W + 1;

  // subtract mode, shared by sub and slt
  logic sub_mode;

  // b or its one's complement, depending on sub_mode
  logic [calc_pkg::DATA_W-1:0] b_sel;

  // sign-extended operands and the shared sum
  logic [EXT_W-1:0] a_ext;
  logic [EXT_W-1:0] b_ext;
  logic [EXT_W-1:0] carry_in;
  logic [EXT_W-1:0] sum_ext;

  // per-operation results, picked by op below
  calc_pkg::data_t and_res;
  calc_pkg::data_t or_res;
  calc_pkg::data_t andn_res;
  calc_pkg::data_t orn_res;
  calc_pkg::data_t arith_res;
  calc_pkg::data_t slt_res;

  logic less; // a < b, signed

  // bit 2 of op and bit 1 together select the arithmetic half that subtracts
  assign sub_mode = (op == alu_pkg::OP_SUB) || (op == alu_pkg::OP_SLT);

  assign b_sel = sub_mode ? ~b : b;

  // extend by the sign bit so the top of the sum holds the true sign
  assign a_ext = {a[calc_pkg::DATA_W-1], a};
  assign b_ext = {b_sel[calc_pkg::DATA_W-1], b_sel};

  // +1 completes the two's complement of b in sub mode
  assign carry_in = {{calc_pkg::DATA_W{1'b0}}, sub_mode};

  // one adder for add, sub and slt
  assign sum_ext = a_ext + b_ext + carry_in;

  // add and sub wrap at 4 bits, drop the extension bit
  assign arith_res = sum_ext[calc_pkg::DATA_W-1:0];

  // difference a - b spans -15..15, so bit 4 is its sign
  assign less = sum_ext[EXT_W-1];

  assign slt_res = {{(calc_pkg::DATA_W-1){1'b0}}, less};

  // bitwise ops
  assign and_res  = a & b;
  assign or_res   = a | b;
  assign andn_res = a & ~b;
  assign orn_res  = a | ~b;

  // result select
  always_comb begin
    case (op)
      alu_pkg::OP_AND: begin
        result = and_res;
      end
      alu_pkg::OP_OR: begin
        result = or_res;
      end
      alu_pkg::OP_ADD: begin
        result = arith_res;
      end
      alu_pkg::OP_ZERO: begin
        result = '0;
      end
      alu_pkg::OP_ANDN: begin
        result = andn_res;
      end
      alu_pkg::OP_ORN: begin
        result = orn_res;
      end
      alu_pkg::OP_SUB: begin
        result = arith_res; // same adder, sub_mode set
      end
      alu_pkg::OP_SLT: begin
        result = slt_res;
      end
      default: begin
        result = '0; // unknown code reads as zero
      end
    endcase
  end

endmodule

/* calc_regfile.sv */
`timescale 1ns/1ps

module calc_regfile (
  input  logic                clk,
  input  logic                arst_n,
  input  calc_pkg::reg_addr_t rd_addr,
  input  calc_pkg::reg_addr_t we_addr,
  input  calc_pkg::data_t     we_data,
  output calc_pkg::data_t     rd_data
);

  // register storage
  calc_pkg::data_t regs [calc_pkg::NUM_REGS];

  // one-hot write select from we_addr
  logic [calc_pkg::NUM_REGS-1:0] we_sel;

  // write address decode
  // exactly one bit is set, there is no write enable
  always_comb begin
    we_sel = '0;
    we_sel[we_addr] = 1'b1;
  end

  // write-back, every edge out of reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < calc_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      for (int i = 0; i < calc_pkg::NUM_REGS; i++) begin
        if (we_sel[i]) begin
          regs[i] <= we_data;
        end
      end
    end
  end

  // read mux, no latency
  // when rd_addr == we_addr the old value is read until the edge
  always_comb begin
    case (rd_addr)
      2'd0: begin
        rd_data = regs[0];
      end
      2'd1: begin
        rd_data = regs[1];
      end
      2'd2: begin
        rd_data = regs[2];
      end
      default: begin
        rd_data = regs[3];
      end
    endcase
  end

endmodule

/* calculator.sv */
`timescale 1ns/1ps

module calculator (
  input  logic                clk,
  input  logic                arst_n,
  input  calc_pkg::reg_addr_t rd_addr,   // source register
  input  calc_pkg::data_t     immediate, // second operand
  input  calc_pkg::reg_addr_t we_addr,   // destination register
  input  alu_pkg::alu_op_t    control,   // operation select
  output calc_pkg::data_t     rd_data    // source register, always visible
);

  // ALU output, written back at the next rising edge
  calc_pkg::data_t alu_result;

  // storage, read side feeds both rd_data and operand a
  calc_regfile regfile_i (
    .clk     (clk),
    .arst_n  (arst_n),
    .rd_addr (rd_addr),
    .we_addr (we_addr),
    .we_data (alu_result),
    .rd_data (rd_data)
  );

  // compute stage
  // a from the register, b from the immediate
  calc_alu alu_i (
    .a      (rd_data),
    .b      (immediate),
    .op     (control),
    .result (alu_result)
  );

endmodule

/* calculator_asserts.sv */
`timescale 1ns/1ps

module calculator_asserts (
  input logic                clk,
  input logic                arst_n,
  input calc_pkg::reg_addr_t rd_addr,
  input calc_pkg::reg_addr_t we_addr,
  input alu_pkg::alu_op_t    control,
  input calc_pkg::data_t     rd_data,
  input calc_pkg::data_t     alu_result
);

  // high once a full write cycle has passed since reset
  logic past_valid;

  int unsigned fail_count = 0; // failed assertions so far

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      past_valid <= 1'b0;
    end else begin
      past_valid <= 1'b1;
    end
  end

  // inputs must be driven out of reset
  inputs_known: assert property (
    @(posedge clk) disable iff (!arst_n)
    !$isunknown({control, rd_addr, we_addr})
  ) else begin
    $error("control or address unknown out of reset");
    fail_count++;
  end

  reset_clears: assert property (
    @(posedge clk) !arst_n |-> rd_data == '0
  ) else begin
    $error("rd_data not zero during reset");
    fail_count++;
  end

  // last edge's result visible when reading the written register
  write_visible: assert property (
    @(posedge clk) disable iff (!arst_n)
    (past_valid && rd_addr == $past(we_addr)) |-> rd_data == $past(alu_result)
  ) else begin
    $error("written value not seen on rd_data");
    fail_count++;
  end

endmodule

bind calculator calculator_asserts asserts_i (
  .clk        (clk),
  .arst_n     (arst_n),
  .rd_addr    (rd_addr),
  .we_addr    (we_addr),
  .control    (control),
  .rd_data    (rd_data),
  .alu_result (alu_result)
);

/* tb_calculator.sv */
`timescale 1ns/1ps

module tb_calculator;

  localparam int CLK_PERIOD = 100; // ns
  localparam int RESET_CYCLES = 5;
  localparam int SEED = 32'h7af2c6d5;

  // cycle budget of each test, summed for the watchdog
  localparam int RESET_TEST_CYCLES = 2 * RESET_CYCLES + 20;
  localparam int ADDR_TEST_CYCLES = 12;
  localparam int OPS_TEST_CYCLES = 2 * 8 * 4; // two operand pairs, 4 cycles per op
  localparam int EDGE_TEST_CYCLES = 7 * 4;
  localparam int INPLACE_TEST_CYCLES = 10;
  localparam int RANDOM_CYCLES = 200;
  localparam int MARGIN_CYCLES = 50;
  localparam int TOTAL_CYCLES = RESET_TEST_CYCLES + ADDR_TEST_CYCLES + OPS_TEST_CYCLES
                              + EDGE_TEST_CYCLES + INPLACE_TEST_CYCLES + RANDOM_CYCLES;
  localparam int TIMEOUT_NS = (TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic                clk;
  logic                arst_n;
  calc_pkg::reg_addr_t rd_addr;
  calc_pkg::data_t     immediate;
  calc_pkg::reg_addr_t we_addr;
  alu_pkg::alu_op_t    control;
  calc_pkg::data_t     rd_data;

  // expected register contents
  calc_pkg::data_t model [calc_pkg::NUM_REGS];

  calculator calculator_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .rd_addr   (rd_addr),
    .immediate (immediate),
    .we_addr   (we_addr),
    .control   (control),
    .rd_data   (rd_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // expected ALU result, straight from the operation table
  function automatic calc_pkg::data_t alu_ref(input calc_pkg::data_t a,
                                              input calc_pkg::data_t b,
                                              input alu_pkg::alu_op_t op);
    int sa;
    int sb;
    int wide;
    calc_pkg::data_t res;
    sa = int'(a); // signed values
    sb = int'(b);
    wide = 0;
    case (op)
      alu_pkg::OP_AND: res = a & b;
      alu_pkg::OP_OR: res = a | b;
      alu_pkg::OP_ADD: begin
        wide = sa + sb;
        res = wide[calc_pkg::DATA_W-1:0]; // wraps at 4 bits
      end
      alu_pkg::OP_ZERO: res = '0;
      alu_pkg::OP_ANDN: res = a & ~b;
      alu_pkg::OP_ORN: res = a | ~b;
      alu_pkg::OP_SUB: begin
        wide = sa - sb;
        res = wide[calc_pkg::DATA_W-1:0];
      end
      alu_pkg::OP_SLT: res = (sa < sb) ? calc_pkg::data_t'(1) : calc_pkg::data_t'(0);
      default: res = '0;
    endcase
    return res;
  endfunction

  // model register file, one write per edge out of reset
  always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < calc_pkg::NUM_REGS; i++) begin
        model[i] <= '0;
      end
    end else begin
      model[we_addr] <= alu_ref(model[rd_addr], immediate, control);
    end
  end

  task automatic compare_values(input calc_pkg::data_t actual,
                                input calc_pkg::data_t expected,
                                input string what);
    if (actual !== expected) begin
      $display("error: %0t ns: %s, got %0d, expected %0d", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // one cycle of inputs, takes effect at the next edge
  task automatic drive_cycle(input calc_pkg::reg_addr_t rd, input calc_pkg::data_t imm,
                             input calc_pkg::reg_addr_t we, input alu_pkg::alu_op_t op);
    @(posedge clk);
    rd_addr   <= rd;
    immediate <= imm;
    we_addr   <= we;
    control   <= op;
  endtask

  // read a register without changing it, r = r | 0
  task automatic check_reg(input calc_pkg::reg_addr_t addr, input calc_pkg::data_t expected,
                           input string what);
    drive_cycle(addr, '0, addr, alu_pkg::OP_OR);
    @(negedge clk);
    compare_values(rd_data, expected, what);
    compare_values(rd_data, model[addr], {what, " vs model"});
  endtask

  task automatic load_reg(input calc_pkg::reg_addr_t addr, input calc_pkg::data_t value);
    drive_cycle(addr, '0, addr, alu_pkg::OP_ZERO);
    drive_cycle(addr, value, addr, alu_pkg::OP_ADD); // 0 + value
  endtask

  task automatic apply_reset;
    @(posedge clk);
    arst_n <= 1'b0;
    for (int i = 0; i < RESET_CYCLES - 1; i++) begin
      check_reg(calc_pkg::reg_addr_t'(i % calc_pkg::NUM_REGS), '0, "read during reset");
    end
    @(posedge clk);
    arst_n <= 1'b1;
  endtask

  task automatic test_reset;
    apply_reset();
    for (int i = 0; i < calc_pkg::NUM_REGS; i++) begin
      check_reg(calc_pkg::reg_addr_t'(i), '0, "read after reset");
    end
    // fill, then clear again mid-run
    for (int i = 0; i < calc_pkg::NUM_REGS; i++) begin
      load_reg(calc_pkg::reg_addr_t'(i), calc_pkg::data_t'(i + 5));
    end
    check_reg(2'd1, 4'sd6, "value before second reset");
    apply_reset();
    for (int i = 0; i < calc_pkg::NUM_REGS; i++) begin
      check_reg(calc_pkg::reg_addr_t'(i), '0, "read after second reset");
    end
  endtask

  task automatic test_addressing;
    calc_pkg::data_t vals [calc_pkg::NUM_REGS];
    vals = '{4'sd3, -4'sd5, 4'sd6, -4'sd1};
    for (int i = 0; i < calc_pkg::NUM_REGS; i++) begin
      drive_cycle(calc_pkg::reg_addr_t'(i), '0, calc_pkg::reg_addr_t'(i), alu_pkg::OP_ZERO);
      drive_cycle(calc_pkg::reg_addr_t'(i), vals[i], calc_pkg::reg_addr_t'(i),
                  alu_pkg::OP_ADD);
    end
    for (int i = 0; i < calc_pkg::NUM_REGS; i++) begin
      check_reg(calc_pkg::reg_addr_t'(i), vals[i], $sformatf("register %0d readback", i));
    end
  endtask

  // load a into r1, r2 = r1 op b, then read r2
  task automatic apply_and_check(input calc_pkg::data_t a, input calc_pkg::data_t b,
                                 input alu_pkg::alu_op_t op, input calc_pkg::data_t expected,
                                 input string what);
    load_reg(2'd1, a);
    drive_cycle(2'd1, b, 2'd2, op);
    check_reg(2'd2, expected, what);
  endtask

  task automatic test_each_op;
    calc_pkg::data_t a_vals [2];
    calc_pkg::data_t b_vals [2];
    alu_pkg::alu_op_t op;
    a_vals = '{4'sd5, -4'sd6};
    b_vals = '{4'sd3, 4'sd3};
    for (int p = 0; p < 2; p++) begin
      for (int k = 0; k < 8; k++) begin
        op = alu_pkg::alu_op_t'(k);
        apply_and_check(a_vals[p], b_vals[p], op, alu_ref(a_vals[p], b_vals[p], op),
                        $sformatf("%s with %0d, %0d", op.name(), a_vals[p], b_vals[p]));
      end
    end
  endtask

  task automatic test_signed_edges;
    apply_and_check(4'sd7, 4'sd1, alu_pkg::OP_ADD, -4'sd8, "7 + 1 wraps");
    apply_and_check(-4'sd8, 4'sd1, alu_pkg::OP_SUB, 4'sd7, "-8 - 1 wraps");
    apply_and_check(-4'sd8, -4'sd1, alu_pkg::OP_ADD, 4'sd7, "-8 + -1 wraps");
    apply_and_check(4'sd7, -4'sd8, alu_pkg::OP_SUB, -4'sd1, "7 - -8 wraps");
    apply_and_check(-4'sd8, 4'sd7, alu_pkg::OP_SLT, 4'sd1, "-8 < 7");
    apply_and_check(4'sd7, -4'sd8, alu_pkg::OP_SLT, 4'sd0, "7 < -8");
    apply_and_check(4'sd3, 4'sd3, alu_pkg::OP_SLT, 4'sd0, "3 < 3");
  endtask

  task automatic test_in_place;
    drive_cycle(2'd0, '0, 2'd0, alu_pkg::OP_ZERO);
    drive_cycle(2'd0, 4'sd2, 2'd0, alu_pkg::OP_ADD); // r0 = r0 + 2
    @(negedge clk);
    compare_values(rd_data, '0, "old r0 before in-place write");
    check_reg(2'd0, 4'sd2, "r0 = r0 + 2");
    drive_cycle(2'd0, -4'sd2, 2'd1, alu_pkg::OP_SUB); // r1 = r0 - (-2)
    check_reg(2'd1, 4'sd4, "r1 = r0 - (-2)");
    drive_cycle(2'd1, 4'sd1, 2'd2, alu_pkg::OP_AND); // r2 = r1 & 1
    check_reg(2'd2, 4'sd0, "r2 = r1 and 1");
    drive_cycle(2'd2, 4'sd0, 2'd2, alu_pkg::OP_ADD); // r2 = r2 + 0
    check_reg(2'd2, 4'sd0, "r2 = r2 + 0");
  endtask

  task automatic test_random;
    for (int n = 0; n < RANDOM_CYCLES; n++) begin
      drive_cycle(calc_pkg::reg_addr_t'($urandom_range(3, 0)),
                  calc_pkg::data_t'($urandom_range(15, 0)),
                  calc_pkg::reg_addr_t'($urandom_range(3, 0)),
                  alu_pkg::alu_op_t'($urandom_range(7, 0)));
      @(negedge clk);
      compare_values(rd_data, model[rd_addr], $sformatf("random cycle %0d", n));
    end
  endtask

  // watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish within %0d cycles", TOTAL_CYCLES + MARGIN_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  // bound checker in the DUT
  always @(calculator_i.asserts_i.fail_count) begin
    if (calculator_i.asserts_i.fail_count != 0) begin
      $display("an assertion in the bound checker failed at %0t ns", $time);
      $display("TEST FAILED");
      $fatal(1, "assertion failure");
    end
  end

  initial begin
    void'($urandom(SEED));
    clk       = 1'b0;
    arst_n    = 1'b1; // pulled low at the first edge
    rd_addr   = '0;
    immediate = '0;
    we_addr   = '0;
    control   = alu_pkg::OP_ZERO;

    test_reset();
    test_addressing();
    test_each_op();
    test_signed_edges();
    test_in_place();
    test_random();

    $display("TEST OK");
    $finish;
  end

endmodule

/* files.f */
calc_pkg.sv
alu_pkg.sv
calc_alu.sv
calc_regfile.sv
calculator.sv
calculator_asserts.sv
tb_calculator.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the calculator testbench with Verilator and runs it
# exit status is 0 only when the log shows no failure

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_calculator
BUILD_DIR=obj_dir
LOG_FILE=sim.log

if ! command -v verilator > /dev/null 2>&1; then
  echo "verilator not found in PATH"
  exit 1
fi

verilator --binary --timing --assert \
  -f files.f \
  --top-module "$TOP" \
  --Mdir "$BUILD_DIR" \
  -o "V$TOP"
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "build failed with status $build_status"
  exit 1
fi

if [ ! -x "$BUILD_DIR/V$TOP" ]; then
  echo "simulation binary missing"
  exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -q "TEST FAILED" "$LOG_FILE"; then
  echo "simulation reported failure"
  exit 1
fi

if [ "$run_status" -ne 0 ]; then
  echo "simulator exited with status $run_status"
  exit 1
fi

echo "simulation passed"
exit 0
